//--- compile.f
+incdir+source
source/sdram_pkg.sv
source/axil_slave.sv
source/access_sequencer.sv
source/sdram_init.sv
source/sdram_ctrl_top.sv
testbench/sdram_model.sv
testbench/tb_sdram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only if the log shows the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_sdram_ctrl -o tb_sdram_ctrl

./obj_dir/tb_sdram_ctrl | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
exit 1

//--- source/access_sequencer.sv
`timescale 1ns/100ps
`include "sdram_macros.svh"

module access_sequencer (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic                      init_done,
	input  logic                      req_valid,
	input  logic                      req_write,
	input  logic [`AXI_ADDR_W-1:0]    req_addr,
	input  logic [`AXI_DATA_W-1:0]    req_wdata,
	input  logic [`AXI_DATA_W/8-1:0]  req_wstrb,
	input  logic [`SDRAM_DQ_W-1:0]    dq_in,
	output logic                      req_ready,
	output logic                      rsp_valid,
	output logic [`AXI_DATA_W-1:0]    rsp_rdata,
	output sdram_pkg::sdram_cmd_e     user_cmd,
	output logic [`SDRAM_ROW_W-1:0]   user_addr,
	output logic [`SDRAM_BANK_W-1:0]  user_bank,
	output logic [`SDRAM_DQ_W-1:0]    dq_out,
	output logic                      dq_oe,
	output logic [`SDRAM_DM_W-1:0]    dm
);
	import sdram_pkg::*;

	seq_state_e                  state;
	logic [`WAIT_W-1:0]          wait_cnt;   // shared by rcd, cl, rp, rfc
	logic [`REF_CNT_W-1:0]       ref_cnt;
	logic                        ref_pending;

	logic                        wr_q;
	logic [`SDRAM_BANK_W-1:0]    bank_q;
	logic [`SDRAM_ROW_W-1:0]     row_q;
	logic [`SDRAM_COL_W-1:0]     col_q;
	logic [`AXI_DATA_W-1:0]      wdata_q;
	logic [`AXI_DATA_W/8-1:0]    wstrb_q;
	logic [`SDRAM_ROW_W-1:0]     col_ap;     // column with auto-precharge

	assign req_ready = init_done && (state == IDLE) && !ref_pending;
	assign col_ap    = `ADDR_A10 | {{(`SDRAM_ROW_W-`SDRAM_COL_W){1'b0}}, col_q};

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			state       <= IDLE;
			user_cmd    <= CMD_NOP;
			dq_oe       <= 1'b0;
			dm          <= '0;
			rsp_valid   <= 1'b0;
			wait_cnt    <= '0;
			wr_q        <= 1'b0;
			ref_cnt     <= '0;
			ref_pending <= 1'b0;
		end
		else
		begin
			user_cmd  <= CMD_NOP;   // defaults overridden per state
			dq_oe     <= 1'b0;
			dm        <= '0;
			rsp_valid <= 1'b0;
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;

			case (state)
				IDLE:
				begin
					if (ref_pending)
						state <= REFRESH;
					else if (req_valid && req_ready)
					begin
						wr_q    <= req_write;
						bank_q  <= req_addr[`MAP_BANK_HI:`MAP_BANK_LO];
						row_q   <= req_addr[`MAP_ROW_HI:`MAP_ROW_LO];
						col_q   <= {req_addr[`MAP_COL_HI:`MAP_COL_LO], 1'b0};
						wdata_q <= req_wdata;
						wstrb_q <= req_wstrb;
						state   <= ACTIVATE;
					end
				end
				ACTIVATE:
				begin
					user_cmd  <= CMD_ACT;
					user_addr <= row_q;
					user_bank <= bank_q;
					wait_cnt  <= `WAIT_W'(`T_RCD - 1);
					state     <= RCD_WAIT;
				end
				RCD_WAIT:
				begin
					if (wait_cnt == '0)
					begin
						user_addr <= col_ap;
						if (wr_q)
						begin
							user_cmd <= CMD_WRITE;   // low half-word rides with the command
							dq_out   <= wdata_q[`SDRAM_DQ_W-1:0];
							dq_oe    <= 1'b1;
							dm       <= ~wstrb_q[`SDRAM_DM_W-1:0];
							state    <= WRITE_BEATS;
						end
						else
						begin
							user_cmd <= CMD_READ;
							wait_cnt <= `WAIT_W'(`CAS_LAT);
							state    <= READ_WAIT;
						end
					end
				end
				WRITE_BEATS:
				begin
					dq_out   <= wdata_q[`AXI_DATA_W-1:`SDRAM_DQ_W];
					dq_oe    <= 1'b1;
					dm       <= ~wstrb_q[2*`SDRAM_DM_W-1:`SDRAM_DM_W];
					wait_cnt <= `WAIT_W'(`T_RP - 1);
					state    <= PRECHARGE_WAIT;
				end
				READ_WAIT:
				begin
					if (wait_cnt == '0)
					begin
						rsp_rdata[`SDRAM_DQ_W-1:0] <= dq_in;   // first beat
						state                      <= READ_BEATS;
					end
				end
				READ_BEATS:
				begin
					rsp_rdata[`AXI_DATA_W-1:`SDRAM_DQ_W] <= dq_in;
					rsp_valid <= 1'b1;
					wait_cnt  <= `WAIT_W'(`T_RP - 1);
					state     <= PRECHARGE_WAIT;
				end
				PRECHARGE_WAIT:
				begin
					if (wait_cnt == '0)
					begin
						rsp_valid <= wr_q;   // reads already answered
						state     <= IDLE;
					end
				end
				REFRESH:
				begin
					user_cmd    <= CMD_REF;
					user_addr   <= `ADDR_A10;
					ref_pending <= 1'b0;
					wait_cnt    <= `WAIT_W'(`T_RFC - 1);
					state       <= RFC_WAIT;
				end
				RFC_WAIT:
				begin
					if (wait_cnt == '0)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase

			// refresh interval where a new pending wins over the clear above
			if (init_done)
			begin
				if (ref_cnt == `REF_CNT_W'(`REFRESH_INTERVAL - 1))
				begin
					ref_cnt     <= '0;
					ref_pending <= 1'b1;
				end
				else
					ref_cnt <= ref_cnt + 1'b1;
			end
		end
	end

endmodule

//--- source/axil_slave.sv
`timescale 1ns/100ps
`include "sdram_macros.svh"

module axil_slave (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic                      init_done,
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	output logic                      req_valid,
	output logic                      req_write,
	output logic [`AXI_ADDR_W-1:0]    req_addr,
	output logic [`AXI_DATA_W-1:0]    req_wdata,
	output logic [`AXI_DATA_W/8-1:0]  req_wstrb,
	input  logic                      req_ready,
	input  logic                      rsp_valid,
	input  logic [`AXI_DATA_W-1:0]    rsp_rdata
);

	logic aw_got;   // write address captured
	logic w_got;    // write data captured
	logic busy;     // request handed over, waiting for rsp
	logic open_wr;  // no request or response in flight
	logic idle;

	assign open_wr = init_done && !req_valid && !busy && !bvalid && !rvalid;
	assign idle    = open_wr && !aw_got && !w_got;

	assign arready = idle;                              // reads win a tie
	assign awready = open_wr && !aw_got && !(idle && arvalid);
	assign wready  = open_wr && !w_got && !(idle && arvalid);

	assign bresp = 2'b00;
	assign rresp = 2'b00;

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			aw_got    <= 1'b0;
			w_got     <= 1'b0;
			busy      <= 1'b0;
			req_valid <= 1'b0;
			req_write <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
		end
		else
		begin
			if (arvalid && arready)
			begin
				req_addr  <= araddr;
				req_write <= 1'b0;
				req_valid <= 1'b1;
			end
			if (awvalid && awready)
			begin
				req_addr <= awaddr;
				aw_got   <= 1'b1;
			end
			if (wvalid && wready)
			begin
				req_wdata <= wdata;
				req_wstrb <= wstrb;
				w_got     <= 1'b1;
			end
			if (aw_got && w_got)   // both halves of the write are in
			begin
				req_write <= 1'b1;
				req_valid <= 1'b1;
				aw_got    <= 1'b0;
				w_got     <= 1'b0;
			end
			if (req_valid && req_ready)
			begin
				req_valid <= 1'b0;
				busy      <= 1'b1;
			end
			if (rsp_valid)
			begin
				busy <= 1'b0;
				if (req_write)
					bvalid <= 1'b1;
				else
				begin
					rvalid <= 1'b1;
					rdata  <= rsp_rdata;
				end
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

endmodule

//--- source/sdram_ctrl_top.sv
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_ctrl_top (
	input  logic                      CLK_n,
	input  logic                      RST,
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	output logic                      cke,
	output sdram_pkg::sdram_cmd_e     cmd,
	output logic [`SDRAM_ROW_W-1:0]   addr,
	output logic [`SDRAM_BANK_W-1:0]  bank,
	output logic [`SDRAM_DQ_W-1:0]    dq_out,
	output logic                      dq_oe,
	output logic [`SDRAM_DM_W-1:0]    dm,
	input  logic [`SDRAM_DQ_W-1:0]    dq_in
);
	import sdram_pkg::*;

	logic                      init_done;
	logic                      req_valid;
	logic                      req_write;
	logic [`AXI_ADDR_W-1:0]    req_addr;
	logic [`AXI_DATA_W-1:0]    req_wdata;
	logic [`AXI_DATA_W/8-1:0]  req_wstrb;
	logic                      req_ready;
	logic                      rsp_valid;
	logic [`AXI_DATA_W-1:0]    rsp_rdata;
	sdram_cmd_e                user_cmd;   // sequencer side of the pin mux
	logic [`SDRAM_ROW_W-1:0]   user_addr;
	logic [`SDRAM_BANK_W-1:0]  user_bank;

	axil_slave i_axil_slave (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.init_done (init_done),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata)
	);

	access_sequencer i_access_sequencer (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.init_done (init_done),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.dq_in     (dq_in),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.user_cmd  (user_cmd),
		.user_addr (user_addr),
		.user_bank (user_bank),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.dm        (dm)
	);

	sdram_init i_sdram_init (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.user_cmd  (user_cmd),
		.user_addr (user_addr),
		.user_bank (user_bank),
		.cke       (cke),
		.cmd       (cmd),
		.addr      (addr),
		.bank      (bank),
		.init_done (init_done)
	);

endmodule

//--- source/sdram_init.sv
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_init (
	input  logic                     CLK_n,
	input  logic                     RST,
	input  sdram_pkg::sdram_cmd_e    user_cmd,
	input  logic [`SDRAM_ROW_W-1:0]  user_addr,
	input  logic [`SDRAM_BANK_W-1:0] user_bank,
	output logic                     cke,
	output sdram_pkg::sdram_cmd_e    cmd,
	output logic [`SDRAM_ROW_W-1:0]  addr,
	output logic [`SDRAM_BANK_W-1:0] bank,
	output logic                     init_done
);
	import sdram_pkg::*;

	logic [`INIT_PWR_W-1:0]    pwr_cnt;
	logic [`INIT_GAP_W-1:0]    gap_cnt;
	logic [`INIT_SETTLE_W-1:0] settle_cnt;
	logic [2:0]                stage;      // index of next rom entry
	logic                      seq_done;
	logic                      gap_hit;

	sdram_cmd_e                rom_cmd;
	logic [`SDRAM_ROW_W-1:0]   rom_addr;
	logic [`SDRAM_BANK_W-1:0]  rom_bank;

	sdram_cmd_e                init_cmd;
	logic [`SDRAM_ROW_W-1:0]   init_addr;
	logic [`SDRAM_BANK_W-1:0]  init_bank;

	assign seq_done = (stage == 3'd7);
	assign gap_hit  = (gap_cnt == `INIT_GAP_W'(`INIT_GAP - 1));

	// user path owns the pins once init is over
	assign cmd  = init_done ? user_cmd  : init_cmd;
	assign addr = init_done ? user_addr : init_addr;
	assign bank = init_done ? user_bank : init_bank;

	always_comb
	begin
		rom_cmd  = CMD_NOP;
		rom_addr = `ADDR_A10;
		rom_bank = '0;
		case (stage)
			3'd0: rom_cmd = CMD_PRE;   // precharge all
			3'd1:
			begin
				rom_cmd  = CMD_MRS;
				rom_addr = `EXT_MODE_WORD;
				rom_bank = `EXT_MODE_BANK;
			end
			3'd2:
			begin
				rom_cmd  = CMD_MRS;   // mode word plus dll reset
				rom_addr = `MODE_WORD | `MODE_DLL_RESET;
				rom_bank = `MODE_BANK;
			end
			3'd3: rom_cmd = CMD_PRE;
			3'd4: rom_cmd = CMD_REF;
			3'd5: rom_cmd = CMD_REF;
			3'd6:
			begin
				rom_cmd  = CMD_MRS;
				rom_addr = `MODE_WORD;
				rom_bank = `MODE_BANK;
			end
			default: rom_cmd = CMD_NOP;
		endcase
	end

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			cke        <= 1'b0;
			init_done  <= 1'b0;
			pwr_cnt    <= '0;
			gap_cnt    <= '0;
			settle_cnt <= '0;
			stage      <= '0;
			init_cmd   <= CMD_NOP;
			init_addr  <= '0;
			init_bank  <= '0;
		end
		else if (!cke)
		begin
			pwr_cnt <= pwr_cnt + 1'b1;   // power-up wait
			if (pwr_cnt == `INIT_PWR_W'(`INIT_POWERUP - 1))
				cke <= 1'b1;
		end
		else if (!seq_done)
		begin
			if (gap_hit)
			begin
				init_cmd  <= rom_cmd;
				init_addr <= rom_addr;
				init_bank <= rom_bank;
				stage     <= stage + 1'b1;
				gap_cnt   <= '0;
			end
			else
			begin
				init_cmd <= CMD_NOP;
				gap_cnt  <= gap_cnt + 1'b1;
			end
		end
		else if (!init_done)
		begin
			init_cmd   <= CMD_NOP;
			settle_cnt <= settle_cnt + 1'b1;
			if (settle_cnt == `INIT_SETTLE_W'(`INIT_SETTLE - 1))
				init_done <= 1'b1;
		end
	end

endmodule

//--- source/sdram_macros.svh
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

`define SDRAM_ROW_W         13
`define SDRAM_BANK_W        2
`define SDRAM_COL_W         10
`define SDRAM_DQ_W          16
`define SDRAM_DM_W          2
`define AXI_ADDR_W          26
`define AXI_DATA_W          32

`define INIT_POWERUP        1024     // simulation-sized cke low time
`define INIT_GAP            16       // cycles between init commands
`define INIT_SETTLE         256      // after last init command
`define INIT_PWR_W          11
`define INIT_GAP_W          5
`define INIT_SETTLE_W       9

`define T_RCD               3
`define T_RP                3
`define T_RFC               10
`define CAS_LAT             2
`define REFRESH_INTERVAL    780
`define WAIT_W              4        // holds the largest wait load
`define REF_CNT_W           10

`define ADDR_A10            13'h0400 // all banks on PRE or auto-precharge on RD/WR

// mode register with BL2 sequential and CL from CAS_LAT
`define MODE_WORD           {6'b000000, 3'(`CAS_LAT), 1'b0, 3'b001}
`define MODE_DLL_RESET      13'h0100
`define EXT_MODE_WORD       13'h0000
`define MODE_BANK           2'b00
`define EXT_MODE_BANK       2'b01

`define MAP_COL_HI          10       // byte address bits to column 9:1
`define MAP_COL_LO          2
`define MAP_ROW_HI          23
`define MAP_ROW_LO          11
`define MAP_BANK_HI         25
`define MAP_BANK_LO         24

`endif

//--- source/sdram_pkg.sv
package sdram_pkg;

	// {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		CMD_MRS   = 3'b000,
		CMD_REF   = 3'b001,
		CMD_PRE   = 3'b010,
		CMD_ACT   = 3'b011,
		CMD_WRITE = 3'b100,
		CMD_READ  = 3'b101,
		CMD_BST   = 3'b110,
		CMD_NOP   = 3'b111
	} sdram_cmd_e;

	typedef enum logic [3:0] {
		IDLE,
		ACTIVATE,
		RCD_WAIT,
		WRITE_BEATS,
		READ_WAIT,
		READ_BEATS,
		PRECHARGE_WAIT,
		REFRESH,
		RFC_WAIT
	} seq_state_e;

endpackage

//--- testbench/sdram_model.sv
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_model (
	input  logic                     CLK_n,
	input  logic                     cke,
	input  sdram_pkg::sdram_cmd_e    cmd,
	input  logic [`SDRAM_ROW_W-1:0]  addr,
	input  logic [`SDRAM_BANK_W-1:0] bank,
	input  logic [`SDRAM_DQ_W-1:0]   dq_out,
	input  logic                     dq_oe,
	input  logic [`SDRAM_DM_W-1:0]   dm,
	output logic [`SDRAM_DQ_W-1:0]   dq_in,
	output int                       err_count
);
	import sdram_pkg::*;

	logic [15:0] mem [logic [24:0]];   // keyed by {bank, row, col}
	int          cycle;
	logic        open_b [4];
	logic [12:0] act_row [4];
	int          act_cyc [4];
	int          ready_cyc [4];         // end of auto-precharge
	logic        wr_pend;
	logic [24:0] wr_key;
	logic        rd_act;
	int          rd_age;
	logic [24:0] rd_key;

	// unwritten words read back as a pattern of the full key
	function automatic logic [15:0] read_word(input logic [24:0] key);
		if (mem.exists(key))
			return mem[key];
		return key[15:0] ^ {7'b0, key[24:16]};
	endfunction

	task automatic write_beat(input logic [24:0] key);
		logic [15:0] w;
		begin
			w = read_word(key);
			if (!dm[0])
				w[7:0] = dq_out[7:0];
			if (!dm[1])
				w[15:8] = dq_out[15:8];
			mem[key] = w;
		end
	endtask

	initial
	begin
		dq_in     = '0;
		err_count = 0;
		cycle     = 0;
		wr_pend   = 1'b0;
		rd_act    = 1'b0;
		rd_age    = 0;
		for (int b = 0; b < 4; b++)
		begin
			open_b[b]    = 1'b0;
			act_cyc[b]   = 0;
			ready_cyc[b] = 0;
		end
	end

	always @(posedge CLK_n)
	begin
		cycle++;
		if (wr_pend)   // second write beat
		begin
			assert (dq_oe) else
			begin
				$display("dq_oe low on second write beat at %0t", $time);
				err_count++;
			end
			write_beat(wr_key);
			wr_pend = 1'b0;
		end
		if (rd_act)
		begin
			rd_age++;
			if (rd_age == `CAS_LAT - 1)
				dq_in <= read_word(rd_key);
			else if (rd_age == `CAS_LAT)
			begin
				dq_in <= read_word(rd_key + 25'd1);
				rd_act = 1'b0;
			end
		end
		if (cke)
			case (cmd)
				CMD_ACT:
				begin
					assert (!open_b[bank] && cycle >= ready_cyc[bank]) else
					begin
						$display("ACT to bank %0d before precharge done at %0t", bank, $time);
						err_count++;
					end
					open_b[bank]  = 1'b1;
					act_row[bank] = addr;
					act_cyc[bank] = cycle;
				end
				CMD_READ, CMD_WRITE:
				begin
					assert (open_b[bank] && cycle - act_cyc[bank] >= `T_RCD) else
					begin
						$display("read or write to bank %0d violates tRCD at %0t", bank, $time);
						err_count++;
					end
					if (cmd == CMD_WRITE)
					begin
						assert (dq_oe) else
						begin
							$display("dq_oe low on first write beat at %0t", $time);
							err_count++;
						end
						wr_key = {bank, act_row[bank], addr[9:0]};
						write_beat(wr_key);
						wr_key  = wr_key + 25'd1;
						wr_pend = 1'b1;
					end
					else
					begin
						rd_key = {bank, act_row[bank], addr[9:0]};
						rd_act = 1'b1;
						rd_age = 0;
					end
					if (addr[10])   // auto-precharge after the burst
					begin
						open_b[bank]    = 1'b0;
						ready_cyc[bank] = cycle + 2 + `T_RP;
					end
				end
				CMD_PRE:
				begin
					for (int b = 0; b < 4; b++)
						if (addr[10] || b == int'(bank))
						begin
							open_b[b]    = 1'b0;
							ready_cyc[b] = cycle + `T_RP;
						end
				end
				CMD_REF:
				begin
					for (int b = 0; b < 4; b++)
						assert (!open_b[b] && cycle >= ready_cyc[b]) else
						begin
							$display("REF with bank %0d busy at %0t", b, $time);
							err_count++;
						end
				end
				default: ;
			endcase
	end

endmodule

//--- testbench/tb_sdram_ctrl.sv
`timescale 1ns/100ps
`include "sdram_macros.svh"

module tb_sdram_ctrl;
	import sdram_pkg::*;

	localparam int          TIMEOUT    = 3000;     // cycles per wait loop
	localparam int          MAX_ACCESS = 24;       // longest single access
	localparam int          N_ADDR     = 16;
	localparam logic [12:0] MODE_NORM  = 13'h021;  // bl 2, sequential, cl 2

	logic        CLK_n;
	logic        RST;
	logic [25:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [25:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        cke;
	sdram_cmd_e  cmd;
	logic [12:0] addr;
	logic [1:0]  bank;
	logic [15:0] dq_out;
	logic        dq_oe;
	logic [1:0]  dm;
	logic [15:0] dq_in;

	int          errors;
	int          model_errors;
	int          cyc;
	int          init_seen;
	int          last_init_cyc;
	int          ref_count;
	int          last_ref_cyc;
	logic [17:0] init_exp;    // expected {cmd, bank, addr}
	logic        prev_bstall;
	logic        prev_rstall;
	logic [31:0] prev_rdata;
	logic [25:0] sb_addr [N_ADDR];
	logic [31:0] sb_data [N_ADDR];

	sdram_ctrl_top i_dut (.*);

	sdram_model i_model (
		.CLK_n     (CLK_n),
		.cke       (cke),
		.cmd       (cmd),
		.addr      (addr),
		.bank      (bank),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.dm        (dm),
		.dq_in     (dq_in),
		.err_count (model_errors)
	);

	initial CLK_n = 1'b0;
	always #4 CLK_n = ~CLK_n;

	// {cmd, bank, addr} of the n-th init command
	function automatic logic [17:0] init_entry(input int n);
		case (n)
			0, 3:    return {3'(CMD_PRE), 2'b00, 13'h0400};
			1:       return {3'(CMD_MRS), 2'b01, 13'h0000};
			2:       return {3'(CMD_MRS), 2'b00, MODE_NORM | 13'h0100};
			4, 5:    return {3'(CMD_REF), 2'b00, 13'h0400};
			default: return {3'(CMD_MRS), 2'b00, MODE_NORM};
		endcase
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
		input logic [3:0] strb);
		for (int b = 0; b < 4; b++)
			if (strb[b])
				old[8*b +: 8] = nw[8*b +: 8];
		return old;
	endfunction

	task automatic finish_run();
		$display("errors: %0d testbench, %0d protocol, %0d refreshes", errors, model_errors,
			ref_count);
		if (errors == 0 && model_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		errors++;
		$display("timeout at %0t: %s", $time, what);
		finish_run();
	endtask

	// init sequence, refresh spacing and cke checks
	always @(posedge CLK_n)
	begin
		if (RST)
		begin
			cyc++;
			if (!cke)
				assert (cmd == CMD_NOP) else
				begin
					errors++;
					$display("command other than NOP while cke low at %0t", $time);
				end
			if (init_seen < 7 || cyc - last_init_cyc < `INIT_SETTLE)
				assert (!awready && !arready) else
				begin
					errors++;
					$display("AXI ready raised before init finished at %0t", $time);
				end
			if (cmd != CMD_NOP && init_seen < 7)
			begin
				init_exp = init_entry(init_seen);
				assert (cmd == sdram_cmd_e'(init_exp[17:15])) else
				begin
					errors++;
					$display("mismatch at %0t: init command %0d is %s", $time, init_seen,
						cmd.name());
				end
				if (cmd == CMD_MRS)
					assert ({bank, addr} == init_exp[14:0]) else
					begin
						errors++;
						$display("mismatch at %0t: mode word %h bank %0d", $time, addr, bank);
					end
				if (cmd == CMD_PRE)
					assert (addr[10]) else
					begin
						errors++;
						$display("mismatch at %0t: init precharge not to all banks", $time);
					end
				if (init_seen > 0)
					assert (cyc - last_init_cyc >= `INIT_GAP) else
					begin
						errors++;
						$display("init commands too close together at %0t", $time);
					end
				init_seen++;
				last_init_cyc = cyc;
			end
			else if (cmd == CMD_REF && init_seen == 7)
			begin
				if (ref_count > 0)
					assert (cyc - last_ref_cyc <= `REFRESH_INTERVAL + MAX_ACCESS) else
					begin
						errors++;
						$display("refresh gap of %0d cycles at %0t", cyc - last_ref_cyc, $time);
					end
				ref_count++;
				last_ref_cyc = cyc;
			end
		end
	end

	// response channels under back-pressure
	always @(posedge CLK_n)
	begin
		if (!RST)
		begin
			prev_bstall <= 1'b0;
			prev_rstall <= 1'b0;
		end
		else
		begin
			if (prev_bstall)
				assert (bvalid) else
				begin
					errors++;
					$display("bvalid dropped before bready at %0t", $time);
				end
			if (prev_rstall)
				assert (rvalid && rdata == prev_rdata) else
				begin
					errors++;
					$display("mismatch at %0t: rvalid or rdata changed under stall", $time);
				end
			if (bvalid || rvalid)
				assert (!awready && !arready) else
				begin
					errors++;
					$display("new address accepted while a response waits at %0t", $time);
				end
			prev_bstall <= bvalid && !bready;
			prev_rstall <= rvalid && !rready;
			prev_rdata  <= rdata;
		end
	end

	task automatic take_response(input logic is_write, input int stall,
		output logic [31:0] data);
		int t;
		begin
			t = 0;
			while (!(is_write ? bvalid : rvalid))
			begin
				@(negedge CLK_n);
				t++;
				if (t > TIMEOUT)
					fail_timeout("no response from the DUT");
			end
			repeat (stall) @(negedge CLK_n);
			if (is_write)
			begin
				bready = 1'b1;
				assert (bresp == 2'b00) else
				begin
					errors++;
					$display("mismatch at %0t: bresp %b", $time, bresp);
				end
			end
			else
			begin
				rready = 1'b1;
				data   = rdata;
				assert (rresp == 2'b00) else
				begin
					errors++;
					$display("mismatch at %0t: rresp %b", $time, rresp);
				end
			end
			@(negedge CLK_n);
			bready = 1'b0;
			rready = 1'b0;
		end
	endtask

	task automatic axi_write(input logic [25:0] a, input logic [31:0] d, input logic [3:0] s,
		input int stall);
		int          t;
		logic        aw_hs;
		logic        w_hs;
		logic [31:0] unused;
		begin
			@(negedge CLK_n);
			awaddr  = a;
			awvalid = 1'b1;
			wdata   = d;
			wstrb   = s;
			wvalid  = 1'b1;
			t       = 0;
			while (awvalid || wvalid)
			begin
				#1;
				aw_hs = awvalid && awready;
				w_hs  = wvalid && wready;
				@(negedge CLK_n);
				if (aw_hs)
					awvalid = 1'b0;
				if (w_hs)
					wvalid = 1'b0;
				t++;
				if (t > TIMEOUT)
					fail_timeout("write address or data never accepted");
			end
			take_response(1'b1, stall, unused);
		end
	endtask

	task automatic axi_read(input logic [25:0] a, input int stall, output logic [31:0] d);
		int t;
		begin
			@(negedge CLK_n);
			araddr  = a;
			arvalid = 1'b1;
			t       = 0;
			#1;
			while (!arready)
			begin
				@(negedge CLK_n);
				#1;
				t++;
				if (t > TIMEOUT)
					fail_timeout("read address never accepted");
			end
			@(negedge CLK_n);
			arvalid = 1'b0;
			take_response(1'b0, stall, d);
		end
	endtask

	task automatic check_read(input int i, input int stall);
		logic [31:0] got;
		begin
			axi_read(sb_addr[i], stall, got);
			assert (got == sb_data[i]) else
			begin
				errors++;
				$display("mismatch at %0t: addr %h read %h expected %h", $time, sb_addr[i],
					got, sb_data[i]);
			end
		end
	endtask

	initial
	begin
		int          t;
		int          i;
		int          stall;
		int          refs_before;
		logic [31:0] d;
		logic [3:0]  s;

		void'($urandom(32'h7ee0));
		errors        = 0;
		cyc           = 0;
		init_seen     = 0;
		last_init_cyc = 0;
		ref_count     = 0;
		last_ref_cyc  = 0;
		RST     = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (10) @(posedge CLK_n);
		@(negedge CLK_n);
		RST = 1'b1;

		t = 0;
		while (!awready)   // rises with init_done
		begin
			@(negedge CLK_n);
			t++;
			if (t > TIMEOUT)
				fail_timeout("initialization never finished");
		end

		// all banks and random rows with index bits keeping columns distinct
		for (int n = 0; n < N_ADDR; n++)
			sb_addr[n] = {2'(n % 4), 13'($urandom), 4'(n), 5'($urandom), 2'b00};

		for (int n = 0; n < N_ADDR; n++)
		begin
			d = $urandom;
			axi_write(sb_addr[n], d, 4'hf, 0);
			sb_data[n] = d;
			check_read(n, 0);
		end

		for (int n = 0; n < 300; n++)
		begin
			i     = $urandom_range(N_ADDR - 1);
			stall = ($urandom_range(3) == 0) ? $urandom_range(15) : 0;
			if ($urandom_range(1) == 1)
			begin
				d = $urandom;
				s = 4'($urandom);
				axi_write(sb_addr[i], d, s, stall);
				sb_data[i] = merge_bytes(sb_data[i], d, s);
			end
			else
				check_read(i, stall);
		end

		// long stalls on each response channel while refresh keeps going
		refs_before = ref_count;
		check_read(3, `REFRESH_INTERVAL + 100);
		assert (ref_count > refs_before) else
		begin
			errors++;
			$display("no refresh while rready was held low");
		end
		refs_before = ref_count;
		axi_write(sb_addr[5], 32'h5a5a_c3c3, 4'hf, `REFRESH_INTERVAL + 100);
		sb_data[5] = 32'h5a5a_c3c3;
		assert (ref_count > refs_before) else
		begin
			errors++;
			$display("no refresh while bready was held low");
		end
		check_read(5, 0);

		t = 0;
		while (ref_count < 3)
		begin
			@(negedge CLK_n);
			t++;
			if (t > TIMEOUT)
				fail_timeout("fewer than three refreshes seen");
		end
		finish_run();
	end

endmodule
